/* carib_pkg.sv */
`default_nettype none

package carib_pkg;

  // ====================================================================
  // Widths
  // ====================================================================
  localparam int DATA_W   = 8;   // Register and SMI byte
  localparam int IOC_W    = 5;   // Register address inside a module
  localparam int SEL_W    = 2;   // Module select
  localparam int SAMPLE_W = 32;  // One I/Q sample

  // Modem framing, I sync opens the word and Q sync sits at bits 15:14
  localparam logic [1:0] I_SYNC = 2'b10;
  localparam logic [1:0] Q_SYNC = 2'b01;

  // Read mux constants
  localparam logic [DATA_W-1:0] VERSION       = 8'h01;
  localparam logic [DATA_W-1:0] RESERVED_BYTE = 8'hA5;

  // Module select codes
  localparam logic [SEL_W-1:0] SEL_IO  = 2'd1;
  localparam logic [SEL_W-1:0] SEL_SMI = 2'd2;

  // ====================================================================
  // Register map
  // ====================================================================
  localparam logic [IOC_W-1:0] IOC_RF_MODE     = 5'd1;  // io_ctrl
  localparam logic [IOC_W-1:0] IOC_LEDS        = 5'd2;
  localparam logic [IOC_W-1:0] IOC_INPUTS      = 5'd3;
  localparam logic [IOC_W-1:0] IOC_FIFO_STATUS = 5'd1;  // smi_ctrl
  localparam logic [IOC_W-1:0] IOC_OVERFLOW    = 5'd2;

  typedef enum logic [1:0] {RF_LOW_POWER, RF_RX09, RF_RX24, RF_TX} rf_mode_t;

  // Register bus from the SPI slave, 17 bits
  typedef struct packed {
    logic [SEL_W-1:0]  sel;
    logic [IOC_W-1:0]  ioc;
    logic [DATA_W-1:0] wdata;
    logic              wr;     // One-cycle write strobe
    logic              rd;     // One-cycle read strobe
  } reg_bus_t;

  // Front-end switch and LNA lines
  typedef struct packed {
    logic rx_h_tx_l;
    logic rx_h_tx_l_b;
    logic tr_vc1;
    logic tr_vc1_b;
    logic tr_vc2;
    logic shdn_rx_lna;
    logic shdn_tx_lna;
  } rf_ctrl_t;

  typedef struct packed {
    logic [1:0]  i_sync;
    logic [13:0] i_val;
    logic [1:0]  q_sync;
    logic [13:0] q_val;
  } iq_sample_t;

endpackage

`default_nettype wire

/* cariboulite_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cariboulite_top import carib_pkg::*; #(
  parameter int FIFO_AW         = 10,  // 1024 samples
  parameter int SPI_SYNC_STAGES = 2
) (
  input  wire        i_glob_clock,
  input  wire        i_rst_b,
  // RF front end
  output logic       o_rx_h_tx_l,
  output logic       o_rx_h_tx_l_b,
  output logic       o_tr_vc1,
  output logic       o_tr_vc1_b,
  output logic       o_tr_vc2,
  output logic       o_shdn_rx_lna,
  output logic       o_shdn_tx_lna,
  // Modem LVDS, already sampled as bit pairs
  input  wire  [1:0] i_iq_rx_09,
  input  wire  [1:0] i_iq_rx_24,
  // Digital I/O
  input  wire  [3:0] i_config,
  input  wire        i_button,
  output logic       o_led0,
  output logic       o_led1,
  // SMI
  input  wire        i_smi_a2,       // Data direction, 1 drives the bus
  input  wire        i_smi_a3,       // Channel select, 0 is 0.9 GHz
  input  wire        i_smi_soe_se,
  output logic [7:0] o_smi_data,
  output logic       o_smi_data_oe,
  output logic       o_smi_read_req,
  // SPI
  input  wire        i_mosi,
  input  wire        i_sck,
  input  wire        i_ss,
  output logic       o_miso
);

  reg_bus_t          bus;
  logic [DATA_W-1:0] io_rdata;
  logic [DATA_W-1:0] smi_rdata;
  logic [DATA_W-1:0] rdata_q;   // Held read byte for the SPI slave
  logic              rd_d;
  rf_ctrl_t          rf;
  logic [1:0]        leds;
  iq_sample_t        s09, s24, fifo_in, fifo_out;
  logic              v09, v24;
  logic              fifo_push, fifo_pull, fifo_empty, fifo_full;
  logic [DATA_W-1:0] overflow;

  // ====================================================================
  // Control path
  // ====================================================================
  spi_slave #(.SYNC_STAGES(SPI_SYNC_STAGES)) spi_i (
    .i_glob_clock, .i_rst_b, .i_sck, .i_ss, .i_mosi,
    .i_rdata(rdata_q), .o_miso, .o_bus(bus)
  );

  io_ctrl io_i (
    .i_glob_clock, .i_rst_b, .i_bus(bus), .i_config, .i_button,
    .o_rdata(io_rdata), .o_rf(rf), .o_leds(leds)
  );

  // Read mux, picked one cycle after rd by the same command's select
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) rd_d <= 1'b0;
    else          rd_d <= bus.rd;
  end

  always_ff @(posedge i_glob_clock) begin
    if (rd_d) begin
      case (bus.sel)
        {SEL_W{1'b0}}: rdata_q <= VERSION;
        SEL_IO:        rdata_q <= io_rdata;
        SEL_SMI:       rdata_q <= smi_rdata;
        default:       rdata_q <= RESERVED_BYTE;  // Select 3 is reserved
      endcase
    end
  end

  assign {o_rx_h_tx_l, o_rx_h_tx_l_b, o_tr_vc1, o_tr_vc1_b,
          o_tr_vc2, o_shdn_rx_lna, o_shdn_tx_lna} = rf;
  assign o_led0 = leds[0];
  assign o_led1 = leds[1];

  // ====================================================================
  // Receive path
  // ====================================================================
  lvds_rx rx09_i (.i_glob_clock, .i_rst_b, .i_pair(i_iq_rx_09), .o_sample(s09), .o_valid(v09));
  lvds_rx rx24_i (.i_glob_clock, .i_rst_b, .i_pair(~i_iq_rx_24), .o_sample(s24), .o_valid(v24));
  // 2.4 GHz pair is routed to the N pin on the board, hence the inversion

  assign fifo_push = i_smi_a3 ? v24 : v09;
  assign fifo_in   = i_smi_a3 ? s24 : s09;

  sample_fifo #(.AW(FIFO_AW)) fifo_i (
    .i_glob_clock, .i_rst_b, .i_push(fifo_push), .i_data(fifo_in), .i_pull(fifo_pull),
    .o_data(fifo_out), .o_empty(fifo_empty), .o_full(fifo_full), .o_overflow(overflow)
  );

  smi_ctrl smi_i (
    .i_glob_clock, .i_rst_b, .i_bus(bus), .i_smi_a2, .i_smi_soe_se,
    .i_fifo_data(fifo_out), .i_fifo_empty(fifo_empty), .i_fifo_full(fifo_full),
    .i_overflow(overflow), .o_rdata(smi_rdata), .o_fifo_pull(fifo_pull),
    .o_smi_data, .o_smi_data_oe, .o_smi_read_req
  );

endmodule

`default_nettype wire

/* io_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module io_ctrl import carib_pkg::*; (
  input  wire               i_glob_clock,
  input  wire               i_rst_b,
  input  reg_bus_t          i_bus,
  input  wire  [3:0]        i_config,
  input  wire               i_button,
  output logic [DATA_W-1:0] o_rdata,
  output rf_ctrl_t          o_rf,
  output logic [1:0]        o_leds
);

  rf_mode_t rf_mode;
  logic     is_rx;
  logic     sel_hit;

  assign sel_hit = (i_bus.sel == SEL_IO);

  // ====================================================================
  // Registers
  // ====================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      rf_mode <= RF_LOW_POWER;         // Both LNAs shut down
      o_leds  <= 2'b00;
    end else if (i_bus.wr && sel_hit) begin
      case (i_bus.ioc)
        IOC_RF_MODE: rf_mode <= rf_mode_t'(i_bus.wdata[1:0]);
        IOC_LEDS:    o_leds  <= i_bus.wdata[1:0];
        default:     ;                 // Unmapped, ignored
      endcase
    end
  end

  // Read byte captured on the rd strobe
  always_ff @(posedge i_glob_clock) begin
    if (i_bus.rd && sel_hit) begin
      case (i_bus.ioc)
        IOC_RF_MODE: o_rdata <= {6'd0, rf_mode};
        IOC_LEDS:    o_rdata <= {6'd0, o_leds};
        IOC_INPUTS:  o_rdata <= {3'd0, i_button, i_config};
        default:     o_rdata <= '0;
      endcase
    end
  end

  // Switch decode
  assign is_rx              = (rf_mode == RF_RX09) || (rf_mode == RF_RX24);
  assign o_rf.rx_h_tx_l     = (rf_mode != RF_TX);   // Low power parks on RX side
  assign o_rf.rx_h_tx_l_b   = (rf_mode == RF_TX);
  assign o_rf.tr_vc1        = (rf_mode == RF_RX09);
  assign o_rf.tr_vc1_b      = (rf_mode != RF_RX09);
  assign o_rf.tr_vc2        = (rf_mode == RF_RX24);
  assign o_rf.shdn_rx_lna   = ~is_rx;
  assign o_rf.shdn_tx_lna   = (rf_mode != RF_TX);

endmodule

`default_nettype wire

/* lvds_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module lvds_rx import carib_pkg::*; (
  input  wire        i_glob_clock,
  input  wire        i_rst_b,
  input  wire  [1:0] i_pair,      // Two bits per clock, MSB first
  output iq_sample_t o_sample,
  output logic       o_valid      // One-cycle pulse per good sample
);

  // Pairs after the start pair, counted from 0
  localparam int LAST_PAIR = SAMPLE_W / 2 - 2;

  logic                busy;       // Collecting a sample
  logic [3:0]          cnt;
  logic [SAMPLE_W-3:0] sr;         // Pairs received so far
  iq_sample_t          word;       // Sample including this cycle's pair

  assign word = {sr, i_pair};

  // ====================================================================
  // Framing FSM
  // ====================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      busy    <= 1'b0;
      cnt     <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      if (!busy) begin
        if (i_pair == I_SYNC) begin    // Hunting for start of sample
          busy <= 1'b1;
          cnt  <= '0;
        end
      end else begin
        cnt <= cnt + 4'd1;
        if (cnt == 4'(LAST_PAIR)) begin
          busy    <= 1'b0;             // Back to hunting either way
          o_valid <= (word.q_sync == Q_SYNC);
        end
      end
    end
  end

  // Shift register and output sample
  always_ff @(posedge i_glob_clock) begin
    sr <= word[SAMPLE_W-3:0];
    if (busy && cnt == 4'(LAST_PAIR)) begin
      o_sample <= word;
    end
  end

  a_valid_pulse: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    o_valid |=> !o_valid)
    else $error("lvds_rx: valid held longer than one cycle");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench and judge the result from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f sim.f -o tb_top \
  && ./obj_dir/tb_top | tee sim.log \
  || echo "Build or simulation run did not complete"
grep -q "^>>> PASS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* rx_tests.dat */
# Columns are an opcode then hex operands. W sel ioc data, R sel ioc expected, I {button,config}
# F channel word corrupt count, S nbytes expected_req bytes, P pins {rx_h_tx_l .. shdn_tx_lna}
# Reset state, version and reserved bytes
P 4B
R 0 00 01
R 3 00 A5
R 3 1F A5
# Input readback
I 1A
R 1 03 1A
I 05
R 1 03 05
# RF modes RX09, RX24, TX and back to low power
W 1 01 01
P 51
W 1 01 02
P 4D
W 1 01 03
P 2A
W 1 01 00
P 4B
R 1 01 00
W 1 02 03
R 1 02 03
# Receive on 0.9 GHz then on 2.4 GHz
R 2 01 01
F 0 81234567 0 1
F 0 9ABC5DEF 0 1
S 8 0 81 23 45 67 9A BC 5D EF
F 1 A55A6BCD 0 1
F 1 B00F7001 0 1
S 8 0 A5 5A 6B CD B0 0F 70 01
# Frames with a bad Q sync are dropped
F 0 87654321 1 1
F 0 8A0B4C0D 0 1
S 4 0 8A 0B 4C 0D
F 1 BEEF6EEF 1 1
F 1 B1234567 0 1
S 4 0 B1 23 45 67
# Overflow with 1100 frames, then 200 more to saturate the counter
F 0 8C3A5A3C 0 44C
R 2 01 02
R 2 02 4C
F 0 8C3A5A3C 0 C8
R 2 02 FF
S 4 1 8C 3A 5A 3C

/* sample_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_fifo import carib_pkg::*; #(
  parameter int AW = 10
) (
  input  wire               i_glob_clock,
  input  wire               i_rst_b,
  input  wire               i_push,
  input  iq_sample_t        i_data,
  input  wire               i_pull,
  output iq_sample_t        o_data,      // Valid the cycle after a pull
  output logic              o_empty,
  output logic              o_full,
  output logic [DATA_W-1:0] o_overflow   // Dropped pushes, saturating
);

  localparam int DEPTH = 1 << AW;

  iq_sample_t  mem [DEPTH];
  logic [AW:0] wptr;               // Extra MSB tells full from empty
  logic [AW:0] rptr;
  logic        do_push;
  logic        do_pull;

  assign o_empty = (wptr == rptr);
  assign o_full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);
  assign do_push = i_push & ~o_full;
  assign do_pull = i_pull & ~o_empty;

  // ====================================================================
  // Pointers and overflow count
  // ====================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      wptr       <= '0;
      rptr       <= '0;
      o_overflow <= '0;
    end else begin
      if (do_push) wptr <= wptr + 1'b1;
      if (do_pull) rptr <= rptr + 1'b1;
      if (i_push && o_full && o_overflow != '1) begin
        o_overflow <= o_overflow + 1'b1;   // Sample lost
      end
    end
  end

  // Storage
  always_ff @(posedge i_glob_clock) begin
    if (do_push) mem[wptr[AW-1:0]] <= i_data;
    if (do_pull) o_data <= mem[rptr[AW-1:0]];
  end

  a_no_pull_empty: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    i_pull |-> !o_empty)
    else $error("sample_fifo: pull while empty");

endmodule

`default_nettype wire

/* sim.f */
carib_pkg.sv
spi_slave.sv
io_ctrl.sv
lvds_rx.sv
sample_fifo.sv
smi_ctrl.sv
cariboulite_top.sv
tb_top.sv

/* smi_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module smi_ctrl import carib_pkg::*; (
  input  wire               i_glob_clock,
  input  wire               i_rst_b,
  input  reg_bus_t          i_bus,
  input  wire               i_smi_a2,       // 1 while the host reads
  input  wire               i_smi_soe_se,   // Read strobe, active low
  input  iq_sample_t        i_fifo_data,
  input  wire               i_fifo_empty,
  input  wire               i_fifo_full,
  input  wire  [DATA_W-1:0] i_overflow,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_fifo_pull,
  output logic [DATA_W-1:0] o_smi_data,
  output logic              o_smi_data_oe,
  output logic              o_smi_read_req
);

  logic [1:0]          soe_sync;
  logic                soe_d;
  logic                take;       // Host took a byte
  logic [SAMPLE_W-1:0] sample_q;   // Loaded sample, next byte on top
  logic                loaded;
  logic                pending;    // Pull issued, data arrives now
  logic [1:0]          byte_idx;

  // ====================================================================
  // Strobe sync and FIFO pull
  // ====================================================================
  assign take           = soe_d & ~soe_sync[1] & i_smi_a2;   // Falling edge
  assign o_fifo_pull    = i_smi_a2 & ~i_fifo_empty & ~loaded & ~pending;
  assign o_smi_read_req = i_smi_a2 & (loaded | pending | ~i_fifo_empty);
  assign o_smi_data_oe  = i_smi_a2;

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      soe_sync   <= 2'b11;            // Strobe idles high
      soe_d      <= 1'b1;
      loaded     <= 1'b0;
      pending    <= 1'b0;
      byte_idx   <= '0;
      o_smi_data <= '0;
    end else begin
      soe_sync <= {soe_sync[0], i_smi_soe_se};
      soe_d    <= soe_sync[1];
      pending  <= o_fifo_pull;
      if (pending) begin
        loaded   <= 1'b1;
        byte_idx <= '0;
      end else if (take && loaded) begin
        byte_idx <= byte_idx + 2'd1;
        if (byte_idx == 2'd3) loaded <= 1'b0;   // Last byte gone, pull next
      end
      if (take) o_smi_data <= loaded ? sample_q[SAMPLE_W-1 -: DATA_W] : '0;
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (pending) begin
      sample_q <= i_fifo_data;
    end else if (take && loaded) begin
      sample_q <= sample_q << DATA_W;   // MSB byte first
    end
  end

  // Status registers
  always_ff @(posedge i_glob_clock) begin
    if (i_bus.rd && i_bus.sel == SEL_SMI) begin
      case (i_bus.ioc)
        IOC_FIFO_STATUS: o_rdata <= {6'd0, i_fifo_full, i_fifo_empty};
        IOC_OVERFLOW:    o_rdata <= i_overflow;
        default:         o_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* spi_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_slave import carib_pkg::*; #(
  parameter int SYNC_STAGES = 2   // At least 2
) (
  input  wire               i_glob_clock,
  input  wire               i_rst_b,
  input  wire               i_sck,
  input  wire               i_ss,
  input  wire               i_mosi,
  input  wire  [DATA_W-1:0] i_rdata,   // Held read byte from the top mux
  output logic              o_miso,
  output reg_bus_t          o_bus
);

  logic [SYNC_STAGES-1:0] sck_sync;
  logic [SYNC_STAGES-1:0] ss_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic                   sck_d;
  logic                   ss_act;
  logic                   sck_rise;
  logic                   sck_fall;
  logic [3:0]             bit_cnt;    // Rising edges seen in this frame
  logic [DATA_W-2:0]      rx_sr;
  logic [DATA_W-1:0]      rx_byte;
  logic [DATA_W-1:0]      tx_sr;
  logic                   cmd_wr;
  logic [SEL_W-1:0]       sel_q;
  logic [IOC_W-1:0]       ioc_q;
  logic [DATA_W-1:0]      wdata_q;
  logic                   wr_q, rd_q;
  logic [1:0]             rd_pipe;    // Bit 1 is the byte load slot

  // ====================================================================
  // Pin synchronizers and edge detect
  // ====================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      sck_sync  <= '0;
      ss_sync   <= '1;   // Deselected
      mosi_sync <= '0;
      sck_d     <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[SYNC_STAGES-2:0], i_sck};
      ss_sync   <= {ss_sync[SYNC_STAGES-2:0], i_ss};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], i_mosi};
      sck_d     <= sck_sync[SYNC_STAGES-1];
    end
  end

  assign ss_act   = ~ss_sync[SYNC_STAGES-1];
  assign sck_rise = ss_act &  sck_sync[SYNC_STAGES-1] & ~sck_d;
  assign sck_fall = ss_act & ~sck_sync[SYNC_STAGES-1] &  sck_d;
  assign rx_byte  = {rx_sr, mosi_sync[SYNC_STAGES-1]};   // Byte incl. current bit

  // ====================================================================
  // Command decode and strobes
  // ====================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      bit_cnt <= '0;
      cmd_wr  <= 1'b0;
      sel_q   <= '0;
      ioc_q   <= '0;
      wr_q    <= 1'b0;
      rd_q    <= 1'b0;
      rd_pipe <= '0;
    end else begin
      wr_q    <= 1'b0;               // Strobes last one cycle
      rd_q    <= 1'b0;
      rd_pipe <= {rd_pipe[0], rd_q};
      if (!ss_act) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd7) begin     // Command byte complete
          cmd_wr <= rx_byte[7];
          sel_q  <= rx_byte[6:5];
          ioc_q  <= rx_byte[4:0];
          rd_q   <= ~rx_byte[7];
        end
        if (bit_cnt == 4'd15) wr_q <= cmd_wr;
      end
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (sck_rise) rx_sr <= rx_byte[DATA_W-2:0];
    if (sck_rise && bit_cnt == 4'd15) wdata_q <= rx_byte;
  end

  assign o_bus = '{sel: sel_q, ioc: ioc_q, wdata: wdata_q, wr: wr_q, rd: rd_q};

  // MISO shifts on falling SCK, MSB first
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b || !ss_act) begin
      tx_sr  <= '0;
      o_miso <= 1'b0;
    end else if (rd_pipe[1]) begin
      tx_sr  <= i_rdata;             // Lands before the next falling SCK
    end else if (sck_fall) begin
      o_miso <= tx_sr[DATA_W-1];
      tx_sr  <= {tx_sr[DATA_W-2:0], 1'b0};
    end
  end

  a_rd_wr_excl: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    !(o_bus.rd && o_bus.wr))
    else $error("spi_slave: rd and wr strobes together");

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_top import carib_pkg::*; ();

  localparam int CLK_HALF      = 10;   // 20 ns period
  localparam int RST_CYCLES    = 5;
  localparam int SCK_HALF      = 8;    // Clocks per SCK half period
  localparam int STROBE_HOLD   = 5;    // Covers the 4-cycle SMI byte latency
  localparam int FRAME_IDLE    = 2;    // Idle pairs after a frame so the push lands
  localparam int REQ_WAIT      = 200;  // Read request timeout in clocks
  localparam int CYCLES_PER_OP = 600;

  logic       clk, rst_b;
  logic [1:0] iq_09, iq_24;
  logic [3:0] cfg;
  logic       button;
  logic       smi_a2, smi_a3, smi_soe;
  logic       mosi, sck, ss;
  logic [7:0] smi_data;
  logic       smi_oe, smi_req, miso, led0, led1;
  rf_ctrl_t   rf_pins;                 // Front-end outputs gathered for checks

  // Parsed test operations
  logic [7:0]  op_code [$];
  logic [31:0] op_a [$];
  logic [31:0] op_b [$];
  logic [31:0] op_c [$];
  logic [31:0] op_d [$];
  logic [7:0]  smi_exp [$];            // Expected SMI bytes in file order
  int          exp_pos, total_weight, errors, checks, fd, idx;
  int          watchdog_cycles;
  bit          tests_loaded;

  cariboulite_top #(.FIFO_AW(10), .SPI_SYNC_STAGES(2)) dut_i (
    .i_glob_clock(clk), .i_rst_b(rst_b),
    .o_rx_h_tx_l(rf_pins.rx_h_tx_l), .o_rx_h_tx_l_b(rf_pins.rx_h_tx_l_b),
    .o_tr_vc1(rf_pins.tr_vc1), .o_tr_vc1_b(rf_pins.tr_vc1_b), .o_tr_vc2(rf_pins.tr_vc2),
    .o_shdn_rx_lna(rf_pins.shdn_rx_lna), .o_shdn_tx_lna(rf_pins.shdn_tx_lna),
    .i_iq_rx_09(iq_09), .i_iq_rx_24(iq_24), .i_config(cfg), .i_button(button),
    .o_led0(led0), .o_led1(led1), .i_smi_a2(smi_a2), .i_smi_a3(smi_a3),
    .i_smi_soe_se(smi_soe), .o_smi_data(smi_data), .o_smi_data_oe(smi_oe),
    .o_smi_read_req(smi_req), .i_mosi(mosi), .i_sck(sck), .i_ss(ss), .o_miso(miso)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ====================================================================
  // Checks and file parsing
  // ====================================================================
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("[ERROR] %0d ns %s got %0h, expected %0h", $time, what, got, exp);
      end
  endtask

  task automatic load_tests(input int fh);
    string       tok;
    logic [7:0]  op;
    logic [31:0] a, b, c, d;
    logic [7:0]  bval;
    int          n, ch, k;
    while (!$feof(fh)) begin
      n = $fscanf(fh, "%s", tok);
      if (n == 1 && tok.getc(0) == "#") begin   // Comment to end of line
        ch = $fgetc(fh);
        while (ch != 10 && ch != -1) ch = $fgetc(fh);
      end else if (n == 1) begin
        a  = '0;
        b  = '0;
        c  = '0;
        d  = 32'd1;                            // Frame repeat count
        op = (tok.len() == 1) ? tok.getc(0) : "?";
        case (op)
          "W", "R": n = $fscanf(fh, "%h %h %h", a, b, c);
          "F":      n = $fscanf(fh, "%h %h %h %h", a, b, c, d);
          "P", "I": n = $fscanf(fh, "%h", a);
          "S": begin
            n = $fscanf(fh, "%h %h", a, b);
            for (k = 0; k < int'(a); k++) begin
              n = $fscanf(fh, "%h", bval);
              smi_exp.push_back(bval);
            end
          end
          default: begin
            errors++;
            $display("Unknown opcode %s in the tests file", tok);
          end
        endcase
        if (op inside {"W", "R", "F", "P", "I", "S"}) begin
          op_code.push_back(op);
          op_a.push_back(a);
          op_b.push_back(b);
          op_c.push_back(c);
          op_d.push_back(d);
          total_weight = total_weight + ((op == "F") ? int'(d) : 1);
        end
      end
    end
  endtask

  // ====================================================================
  // Bus drivers
  // ====================================================================
  // Mode 0 frame of a command byte then a data byte with MISO captured before each rise
  task automatic spi_transfer(input logic [7:0] cmd, input logic [7:0] wbyte,
                              output logic [7:0] rbyte);
    logic [15:0] bits;
    int          i;
    bits  = {cmd, wbyte};
    rbyte = '0;
    ss    = 1'b0;
    for (i = 15; i >= 0; i--) begin
      mosi = bits[i];                   // Set up while SCK is low
      repeat (SCK_HALF) @(negedge clk);
      if (i < 8) rbyte[i] = miso;
      sck = 1'b1;
      repeat (SCK_HALF) @(negedge clk);
      sck = 1'b0;
    end
    repeat (SCK_HALF) @(negedge clk);
    ss = 1'b1;
    repeat (SCK_HALF) @(negedge clk);
  endtask

  task automatic drive_frame(input logic ch, input iq_sample_t word, input logic corrupt);
    logic [1:0] pair;
    int         k;
    if (corrupt) word.q_sync = ~Q_SYNC;
    smi_a3 = ch;                        // FIFO takes this channel
    for (k = 15; k >= 0; k--) begin
      pair = word[2*k +: 2];            // MSB pair first
      if (ch) iq_24 = ~pair;            // 2.4 GHz pins are swapped on the board
      else    iq_09 = pair;
      @(negedge clk);
    end
    iq_09 = 2'b00;                      // Idle pins so both deframers see 00
    iq_24 = 2'b11;
    repeat (FRAME_IDLE) @(negedge clk);
  endtask

  task automatic wait_read_req();
    int n;
    n = 0;
    while (!smi_req && n < REQ_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!smi_req) begin
      errors++;
      $display("SMI read request did not rise within %0d clocks at %0d ns", REQ_WAIT, $time);
    end
  endtask

  task automatic smi_read(input int nbytes, input logic exp_req);
    int k;
    smi_a2 = 1'b1;
    @(negedge clk);
    check_value("SMI data enable", smi_oe, 1);
    for (k = 0; k < nbytes; k++) begin
      wait_read_req();
      smi_soe = 1'b0;                   // Falling edge asks for a byte
      repeat (STROBE_HOLD) @(negedge clk);
      check_value($sformatf("SMI byte %0d", k), smi_data, smi_exp[exp_pos]);
      exp_pos++;
      smi_soe = 1'b1;
      repeat (STROBE_HOLD) @(negedge clk);
    end
    check_value("SMI read request after readout", smi_req, exp_req);
    smi_a2 = 1'b0;
    @(negedge clk);
    check_value("SMI data enable released", smi_oe, 0);
  endtask

  task automatic run_op(input int i);
    logic [7:0]  got;
    logic [31:0] a, b, c, d;
    a = op_a[i];
    b = op_b[i];
    c = op_c[i];
    d = op_d[i];
    case (op_code[i])
      "W": begin
        spi_transfer({1'b1, a[1:0], b[4:0]}, c[7:0], got);
        if (a[1:0] == SEL_IO && b[4:0] == IOC_LEDS) begin
          check_value("LED pins", {led1, led0}, c[1:0]);
        end
      end
      "R": begin
        spi_transfer({1'b0, a[1:0], b[4:0]}, 8'h00, got);
        check_value($sformatf("SPI read sel %0d ioc %0h", a[1:0], b[4:0]), got, c);
      end
      "I": begin
        button = a[4];
        cfg    = a[3:0];
        @(negedge clk);
      end
      "F": repeat (int'(d)) drive_frame(a[0], b, c[0]);
      "P": check_value("RF front-end pins", rf_pins, a);
      "S": smi_read(int'(a), b[0]);
      default: ;
    endcase
  endtask

  // ====================================================================
  // Main sequence and watchdog
  // ====================================================================
  initial begin
    rst_b   = 1'b0;
    iq_09   = 2'b00;
    iq_24   = 2'b11;
    cfg     = 4'h0;
    button  = 1'b0;
    smi_a2  = 1'b0;
    smi_a3  = 1'b0;
    smi_soe = 1'b1;                     // Strobe idles high
    mosi    = 1'b0;
    sck     = 1'b0;
    ss      = 1'b1;
    fd = $fopen("rx_tests.dat", "r");
    if (fd == 0) begin
      $display("Cannot open the tests file rx_tests.dat");
      $display(">>> FAIL");
      $finish;
    end else begin
      load_tests(fd);
      $fclose(fd);
      watchdog_cycles = total_weight * CYCLES_PER_OP;
      tests_loaded    = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      rst_b = 1'b1;
      @(negedge clk);
      check_value("LED pins after reset", {led1, led0}, 0);
      for (idx = 0; idx < op_code.size(); idx++) run_op(idx);
      repeat (10) @(negedge clk);
      $display("Checks run %0d, errors %0d", checks, errors);
      if (errors == 0) $display(">>> PASS");
      else             $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    wait (tests_loaded);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout after %0d clocks, the tests did not finish", watchdog_cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire
